// ==== files.f ====
hdl/ldu_pkg.sv
hdl/ldu_dq_accept.sv
hdl/ldu_dq_launch.sv
hdl/ldu_dq.sv
hdl/ldu_dq_wrapper.sv
testbench/tb_clock_gen.sv
testbench/ldu_dq_sva.sv
testbench/ldu_dq_wrapper_tb.sv

// ==== hdl/ldu_dq.sv ====
`timescale 1ns/1ns

module ldu_dq import ldu_pkg::*; (
	input logic CLK,
	input logic nRST,

	// dispatch
	input logic [dispatch_ways-1:0] dispatch_attempt_by_way,
	input logic [dispatch_ways-1:0] dispatch_valid_by_way,
	input dispatch_op_t [dispatch_ways-1:0] dispatch_op_by_way,
	output logic [dispatch_ways-1:0] dispatch_ack_by_way,

	// writeback
	input wb_bus_t [prf_bank_count-1:0] wb_bus_by_bank,

	// central queue
	output logic ldu_cq_enq_valid,
	output cq_enq_t ldu_cq_enq,
	input logic ldu_cq_enq_ready,
	input logic [log_ldu_cq_entries-1:0] ldu_cq_enq_index,

	// issue queue
	output logic ldu_iq_enq_valid,
	output iq_enq_t ldu_iq_enq,
	input logic ldu_iq_enq_ready,

	// restart from ROB
	input logic rob_restart_valid
);

	dispatch_op_t entry_q [ldu_dq_entries];
	dispatch_op_t entry_d [ldu_dq_entries];

	logic [log_ldu_dq_entries-1:0] head_ptr;
	logic [log_ldu_dq_entries-1:0] tail_ptr;
	logic [log_ldu_dq_entries-1:0] write_index;

	logic [dq_count_width-1:0] entry_count;
	logic [dq_count_width-1:0] free_count;

	logic [dispatch_ways-1:0] write_by_way;
	logic [dispatch_ways-1:0][log_ldu_dq_entries-1:0] write_offset_by_way;
	logic [dq_count_width-1:0] write_count;

	logic head_valid;
	logic pop;

	assign free_count = dq_count_width'(ldu_dq_entries) - entry_count;
	assign head_valid = (entry_count != '0);

	// --------------------------------------------------
	// dispatch acceptance

	ldu_dq_accept u_ldu_dq_accept (
		.dispatch_attempt_by_way(dispatch_attempt_by_way),
		.dispatch_valid_by_way(dispatch_valid_by_way),
		.free_count(free_count),
		.rob_restart_valid(rob_restart_valid),
		.dispatch_ack_by_way(dispatch_ack_by_way),
		.write_by_way(write_by_way),
		.write_offset_by_way(write_offset_by_way),
		.write_count(write_count)
	);

	// --------------------------------------------------
	// storage update: wakeup, then new ops at the tail

	always_comb begin
		write_index = tail_ptr;
		for (int i = 0; i < ldu_dq_entries; i++) begin
			entry_d[i] = entry_q[i];
			if (wb_match(entry_q[i].a_pr, wb_bus_by_bank))
				entry_d[i].a_ready = 1'b1;
		end
		// written slots never hold a live entry, ack already checked space
		for (int w = 0; w < dispatch_ways; w++) begin
			if (write_by_way[w]) begin
				write_index = tail_ptr + write_offset_by_way[w];
				entry_d[write_index] = dispatch_op_by_way[w];
				if (wb_match(dispatch_op_by_way[w].a_pr, wb_bus_by_bank))
					entry_d[write_index].a_ready = 1'b1;
			end
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			for (int i = 0; i < ldu_dq_entries; i++)
				entry_q[i] <= '0;
		end
		else begin
			entry_q <= entry_d;
		end
	end

	// --------------------------------------------------
	// pointers and occupancy

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			entry_count <= '0;
		end
		else if (rob_restart_valid) begin
			// flush, stale entries are simply abandoned
			head_ptr <= '0;
			tail_ptr <= '0;
			entry_count <= '0;
		end
		else begin
			head_ptr <= head_ptr + {{(log_ldu_dq_entries-1){1'b0}}, pop};
			tail_ptr <= tail_ptr + write_count[log_ldu_dq_entries-1:0];
			entry_count <= entry_count + write_count
				- {{(dq_count_width-1){1'b0}}, pop};
		end
	end

	// --------------------------------------------------
	// launch of the oldest op

	ldu_dq_launch u_ldu_dq_launch (
		.head_entry(entry_q[head_ptr]),
		.head_valid(head_valid),
		.wb_bus_by_bank(wb_bus_by_bank),
		.ldu_cq_enq_ready(ldu_cq_enq_ready),
		.ldu_iq_enq_ready(ldu_iq_enq_ready),
		.ldu_cq_enq_index(ldu_cq_enq_index),
		.rob_restart_valid(rob_restart_valid),
		.ldu_cq_enq_valid(ldu_cq_enq_valid),
		.ldu_cq_enq(ldu_cq_enq),
		.ldu_iq_enq_valid(ldu_iq_enq_valid),
		.ldu_iq_enq(ldu_iq_enq),
		.pop(pop)
	);

endmodule

// ==== hdl/ldu_dq_accept.sv ====
`timescale 1ns/1ns

module ldu_dq_accept import ldu_pkg::*; (
	input logic [dispatch_ways-1:0] dispatch_attempt_by_way,
	input logic [dispatch_ways-1:0] dispatch_valid_by_way,

	input logic [dq_count_width-1:0] free_count,
	input logic rob_restart_valid,

	output logic [dispatch_ways-1:0] dispatch_ack_by_way,
	output logic [dispatch_ways-1:0] write_by_way,
	output logic [dispatch_ways-1:0][log_ldu_dq_entries-1:0] write_offset_by_way,
	output logic [dq_count_width-1:0] write_count
);

	logic [way_count_width-1:0] attempt_count;
	logic accept_all;
	logic [dq_count_width-1:0] written_count;

	// --------------------------------------------------
	// ack: all attempting ways or none

	always_comb begin
		attempt_count = '0;
		for (int w = 0; w < dispatch_ways; w++) begin
			attempt_count = attempt_count
				+ {{(way_count_width-1){1'b0}}, dispatch_attempt_by_way[w]};
		end
	end

	assign accept_all = (attempt_count <= free_count) && ~rob_restart_valid;

	assign dispatch_ack_by_way = accept_all ? dispatch_attempt_by_way : '0;

	// --------------------------------------------------
	// writes: acked and valid ways, packed from the tail

	always_comb begin
		written_count = '0;
		for (int w = 0; w < dispatch_ways; w++) begin
			write_by_way[w] = dispatch_ack_by_way[w] & dispatch_valid_by_way[w];
			// rank among the lower written ways
			write_offset_by_way[w] = written_count[log_ldu_dq_entries-1:0];
			written_count = written_count + {{(dq_count_width-1){1'b0}}, write_by_way[w]};
		end
	end

	assign write_count = written_count;

endmodule

// ==== hdl/ldu_dq_launch.sv ====
`timescale 1ns/1ns

module ldu_dq_launch import ldu_pkg::*; (
	input dispatch_op_t head_entry,
	input logic head_valid,

	input wb_bus_t [prf_bank_count-1:0] wb_bus_by_bank,

	input logic ldu_cq_enq_ready,
	input logic ldu_iq_enq_ready,
	input logic [log_ldu_cq_entries-1:0] ldu_cq_enq_index,

	input logic rob_restart_valid,

	output logic ldu_cq_enq_valid,
	output cq_enq_t ldu_cq_enq,

	output logic ldu_iq_enq_valid,
	output iq_enq_t ldu_iq_enq,

	output logic pop
);

	logic launch;

	// both queues must take the op in the same cycle
	assign launch = head_valid & ldu_cq_enq_ready & ldu_iq_enq_ready & ~rob_restart_valid;

	assign ldu_cq_enq_valid = launch;
	assign ldu_iq_enq_valid = launch;
	assign pop = launch;

	// --------------------------------------------------
	// split head entry into the two payloads

	always_comb begin
		ldu_cq_enq = '0;
		ldu_iq_enq = '0;
		if (launch) begin
			ldu_cq_enq.mdp_info = head_entry.mdp_info;
			ldu_cq_enq.dest_pr = head_entry.dest_pr;
			ldu_cq_enq.rob_index = head_entry.rob_index;

			ldu_iq_enq.op = head_entry.op;
			ldu_iq_enq.imm12 = head_entry.imm12;
			ldu_iq_enq.a_pr = head_entry.a_pr;
			// writeback landing this cycle still counts
			ldu_iq_enq.a_ready = head_entry.a_ready
				| wb_match(head_entry.a_pr, wb_bus_by_bank);
			ldu_iq_enq.a_is_zero = head_entry.a_is_zero;
			// slot the central queue hands out this cycle
			ldu_iq_enq.cq_index = ldu_cq_enq_index;
		end
	end

endmodule

// ==== hdl/ldu_dq_wrapper.sv ====
`timescale 1ns/1ns

module ldu_dq_wrapper import ldu_pkg::*; (
	input logic CLK,
	input logic nRST,

	// dispatch
	input logic [dispatch_ways-1:0] next_dispatch_attempt_by_way,
	input logic [dispatch_ways-1:0] next_dispatch_valid_by_way,
	input dispatch_op_t [dispatch_ways-1:0] next_dispatch_op_by_way,
	output logic [dispatch_ways-1:0] last_dispatch_ack_by_way,

	// writeback
	input wb_bus_t [prf_bank_count-1:0] next_wb_bus_by_bank,

	// central queue
	output logic last_ldu_cq_enq_valid,
	output cq_enq_t last_ldu_cq_enq,
	input logic next_ldu_cq_enq_ready,
	input logic [log_ldu_cq_entries-1:0] next_ldu_cq_enq_index,

	// issue queue
	output logic last_ldu_iq_enq_valid,
	output iq_enq_t last_ldu_iq_enq,
	input logic next_ldu_iq_enq_ready,

	// restart from ROB
	input logic next_rob_restart_valid
);

	logic [dispatch_ways-1:0] dispatch_attempt_by_way;
	logic [dispatch_ways-1:0] dispatch_valid_by_way;
	dispatch_op_t [dispatch_ways-1:0] dispatch_op_by_way;
	logic [dispatch_ways-1:0] dispatch_ack_by_way;

	wb_bus_t [prf_bank_count-1:0] wb_bus_by_bank;

	logic ldu_cq_enq_valid;
	cq_enq_t ldu_cq_enq;
	logic ldu_cq_enq_ready;
	logic [log_ldu_cq_entries-1:0] ldu_cq_enq_index;

	logic ldu_iq_enq_valid;
	iq_enq_t ldu_iq_enq;
	logic ldu_iq_enq_ready;

	logic rob_restart_valid;

	ldu_dq u_ldu_dq (
		.CLK(CLK),
		.nRST(nRST),
		.dispatch_attempt_by_way(dispatch_attempt_by_way),
		.dispatch_valid_by_way(dispatch_valid_by_way),
		.dispatch_op_by_way(dispatch_op_by_way),
		.dispatch_ack_by_way(dispatch_ack_by_way),
		.wb_bus_by_bank(wb_bus_by_bank),
		.ldu_cq_enq_valid(ldu_cq_enq_valid),
		.ldu_cq_enq(ldu_cq_enq),
		.ldu_cq_enq_ready(ldu_cq_enq_ready),
		.ldu_cq_enq_index(ldu_cq_enq_index),
		.ldu_iq_enq_valid(ldu_iq_enq_valid),
		.ldu_iq_enq(ldu_iq_enq),
		.ldu_iq_enq_ready(ldu_iq_enq_ready),
		.rob_restart_valid(rob_restart_valid)
	);

	// --------------------------------------------------
	// boundary registers, one stage each way

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			dispatch_attempt_by_way <= '0;
			dispatch_valid_by_way <= '0;
			dispatch_op_by_way <= '0;
			wb_bus_by_bank <= '0;
			ldu_cq_enq_ready <= 1'b0;
			ldu_cq_enq_index <= '0;
			ldu_iq_enq_ready <= 1'b0;
			rob_restart_valid <= 1'b0;

			last_dispatch_ack_by_way <= '0;
			last_ldu_cq_enq_valid <= 1'b0;
			last_ldu_cq_enq <= '0;
			last_ldu_iq_enq_valid <= 1'b0;
			last_ldu_iq_enq <= '0;
		end
		else begin
			// inputs
			dispatch_attempt_by_way <= next_dispatch_attempt_by_way;
			dispatch_valid_by_way <= next_dispatch_valid_by_way;
			dispatch_op_by_way <= next_dispatch_op_by_way;
			wb_bus_by_bank <= next_wb_bus_by_bank;
			ldu_cq_enq_ready <= next_ldu_cq_enq_ready;
			ldu_cq_enq_index <= next_ldu_cq_enq_index;
			ldu_iq_enq_ready <= next_ldu_iq_enq_ready;
			rob_restart_valid <= next_rob_restart_valid;

			// outputs
			last_dispatch_ack_by_way <= dispatch_ack_by_way;
			last_ldu_cq_enq_valid <= ldu_cq_enq_valid;
			last_ldu_cq_enq <= ldu_cq_enq;
			last_ldu_iq_enq_valid <= ldu_iq_enq_valid;
			last_ldu_iq_enq <= ldu_iq_enq;
		end
	end

endmodule

// ==== hdl/ldu_pkg.sv ====
package ldu_pkg;

	// --------------------------------------------------
	// core sizes

	localparam int dispatch_ways = 4;

	localparam int log_pr_count = 6;
	localparam int prf_bank_count = 4;
	localparam int log_prf_bank_count = 2;
	localparam int upper_pr_width = log_pr_count - log_prf_bank_count;

	localparam int log_rob_entries = 7;
	localparam int log_ldu_cq_entries = 4;
	localparam int mdpt_info_width = 8;

	// --------------------------------------------------
	// dispatch queue sizes

	localparam int ldu_dq_entries = 4;
	localparam int log_ldu_dq_entries = 2;

	// occupancy and free counts need one bit more than the pointers
	localparam int dq_count_width = log_ldu_dq_entries + 1;
	// count of attempting ways, 0 to dispatch_ways
	localparam int way_count_width = 3;

	// --------------------------------------------------
	// payloads

	typedef struct packed {
		logic [3:0] op;
		logic [11:0] imm12;
		logic [mdpt_info_width-1:0] mdp_info;
		logic [log_pr_count-1:0] a_pr;
		logic a_ready;
		logic a_is_zero;
		logic [log_pr_count-1:0] dest_pr;
		logic [log_rob_entries-1:0] rob_index;
	} dispatch_op_t;

	typedef struct packed {
		logic valid;
		logic [upper_pr_width-1:0] upper_pr;
	} wb_bus_t;

	typedef struct packed {
		logic [mdpt_info_width-1:0] mdp_info;
		logic [log_pr_count-1:0] dest_pr;
		logic [log_rob_entries-1:0] rob_index;
	} cq_enq_t;

	typedef struct packed {
		logic [3:0] op;
		logic [11:0] imm12;
		logic [log_pr_count-1:0] a_pr;
		logic a_ready;
		logic a_is_zero;
		logic [log_ldu_cq_entries-1:0] cq_index;
	} iq_enq_t;

	// bank picked by the low bits of the register, match on the rest
	function automatic logic wb_match(
		input logic [log_pr_count-1:0] pr,
		input wb_bus_t [prf_bank_count-1:0] wb_bus_by_bank
	);
		wb_bus_t bus;
		bus = wb_bus_by_bank[pr[log_prf_bank_count-1:0]];
		return bus.valid && (bus.upper_pr == pr[log_pr_count-1:log_prf_bank_count]);
	endfunction

endpackage

// ==== testbench/ldu_dq_sva.sv ====
`timescale 1ns/1ns

module ldu_dq_sva import ldu_pkg::*; (
	input logic CLK,
	input logic nRST,
	input logic rob_restart_valid,
	input logic [dispatch_ways-1:0] dispatch_attempt_by_way,
	input logic [dispatch_ways-1:0] dispatch_ack_by_way,
	input logic ldu_cq_enq_valid,
	input logic ldu_iq_enq_valid,
	input logic [dq_count_width-1:0] entry_count
);

	// failed assertions so far
	int assert_fail_count = 0;

	// acked ways must all sit below the first attempting way left unacked
	function automatic logic ack_is_prefix(
		input logic [dispatch_ways-1:0] attempt,
		input logic [dispatch_ways-1:0] ack
	);
		logic gap;
		gap = 1'b0;
		for (int w = 0; w < dispatch_ways; w++) begin
			if (ack[w] && (gap || !attempt[w]))
				return 1'b0;
			if (attempt[w] && !ack[w])
				gap = 1'b1;
		end
		return 1'b1;
	endfunction

	enq_valids_equal: assert property (@(posedge CLK) disable iff (!nRST)
		ldu_cq_enq_valid == ldu_iq_enq_valid)
		else begin
			$error("cq and iq enqueue valids differ");
			assert_fail_count++;
		end

	no_ack_on_restart: assert property (@(posedge CLK) disable iff (!nRST)
		rob_restart_valid |-> (dispatch_ack_by_way == '0))
		else begin
			$error("dispatch acked during restart");
			assert_fail_count++;
		end

	ack_prefix: assert property (@(posedge CLK) disable iff (!nRST)
		ack_is_prefix(dispatch_attempt_by_way, dispatch_ack_by_way))
		else begin
			$error("acked ways are not a prefix of the attempting ways");
			assert_fail_count++;
		end

	count_in_range: assert property (@(posedge CLK) disable iff (!nRST)
		entry_count <= dq_count_width'(ldu_dq_entries))
		else begin
			$error("dispatch queue occupancy above depth");
			assert_fail_count++;
		end

endmodule

bind ldu_dq ldu_dq_sva u_ldu_dq_sva (
	.CLK(CLK),
	.nRST(nRST),
	.rob_restart_valid(rob_restart_valid),
	.dispatch_attempt_by_way(dispatch_attempt_by_way),
	.dispatch_ack_by_way(dispatch_ack_by_way),
	.ldu_cq_enq_valid(ldu_cq_enq_valid),
	.ldu_iq_enq_valid(ldu_iq_enq_valid),
	.entry_count(entry_count)
);

// ==== testbench/ldu_dq_wrapper_tb.sv ====
`timescale 1ns/1ns

module ldu_dq_wrapper_tb import ldu_pkg::*; ();

	localparam int num_cycles = 1500;
	localparam int timeout_ns = (num_cycles + 100) * 10;

	logic CLK;
	logic nRST;

	logic [dispatch_ways-1:0] next_dispatch_attempt_by_way;
	logic [dispatch_ways-1:0] next_dispatch_valid_by_way;
	dispatch_op_t [dispatch_ways-1:0] next_dispatch_op_by_way;
	logic [dispatch_ways-1:0] last_dispatch_ack_by_way;
	wb_bus_t [prf_bank_count-1:0] next_wb_bus_by_bank;
	logic last_ldu_cq_enq_valid;
	cq_enq_t last_ldu_cq_enq;
	logic next_ldu_cq_enq_ready;
	logic [log_ldu_cq_entries-1:0] next_ldu_cq_enq_index;
	logic last_ldu_iq_enq_valid;
	iq_enq_t last_ldu_iq_enq;
	logic next_ldu_iq_enq_ready;
	logic next_rob_restart_valid;

	// model of the input register stage
	logic [dispatch_ways-1:0] m_attempt;
	logic [dispatch_ways-1:0] m_valid;
	dispatch_op_t [dispatch_ways-1:0] m_ops;
	wb_bus_t [prf_bank_count-1:0] m_wb;
	logic m_cq_ready;
	logic [log_ldu_cq_entries-1:0] m_cq_index;
	logic m_iq_ready;
	logic m_restart;

	// queued ops, oldest first, and expected outputs
	dispatch_op_t model_q [$];
	logic [dispatch_ways-1:0] exp_ack;
	logic exp_cq_valid;
	cq_enq_t exp_cq;
	logic exp_iq_valid;
	iq_enq_t exp_iq;

	logic [15:0] lfsr;
	int error_count;
	int assert_errors;
	int check_count;
	int launch_count;
	int ack_count;
	int restart_count;

	tb_clock_gen u_tb_clock_gen (.CLK(CLK), .nRST(nRST));

	ldu_dq_wrapper u_ldu_dq_wrapper (.*);

	// --------------------------------------------------
	// random source

	function automatic logic lfsr_step();
		logic out;
		out = lfsr[0];
		lfsr = (lfsr >> 1) ^ (out ? 16'hB400 : 16'h0000);
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_step()};
		return v;
	endfunction

	// bank b writes back register {upper_pr, b}
	function automatic logic wakes(input logic [log_pr_count-1:0] pr,
		input wb_bus_t [prf_bank_count-1:0] wb);
		logic hit;
		hit = 1'b0;
		for (int b = 0; b < prf_bank_count; b++) begin
			if (wb[b].valid && ({wb[b].upper_pr, log_prf_bank_count'(b)} == pr))
				hit = 1'b1;
		end
		return hit;
	endfunction

	task automatic drive_inputs();
		logic [31:0] hi;
		logic [31:0] lo;
		// mostly sparse attempts, now and then a burst
		if (rand_bits(3) == 0)
			next_dispatch_attempt_by_way = dispatch_ways'(rand_bits(dispatch_ways));
		else
			for (int w = 0; w < dispatch_ways; w++)
				next_dispatch_attempt_by_way[w] = (rand_bits(2) == 0);
		for (int w = 0; w < dispatch_ways; w++) begin
			next_dispatch_valid_by_way[w] = (rand_bits(3) != 0);
			hi = rand_bits(13);
			lo = rand_bits(32);
			next_dispatch_op_by_way[w] = {hi[12:0], lo};
		end
		for (int b = 0; b < prf_bank_count; b++) begin
			next_wb_bus_by_bank[b].valid = (rand_bits(1) != 0);
			next_wb_bus_by_bank[b].upper_pr = upper_pr_width'(rand_bits(upper_pr_width));
		end
		next_ldu_cq_enq_ready = (rand_bits(2) != 0);
		next_ldu_iq_enq_ready = (rand_bits(2) != 0);
		next_ldu_cq_enq_index = log_ldu_cq_entries'(rand_bits(log_ldu_cq_entries));
		next_rob_restart_valid = (rand_bits(6) == 0);
	endtask

	// --------------------------------------------------
	// reference model stepped at each rising edge

	task automatic model_step();
		int attempting;
		int free_slots;
		logic launch;
		dispatch_op_t head;
		dispatch_op_t op;
		attempting = 0;
		for (int w = 0; w < dispatch_ways; w++)
			attempting += m_attempt[w];
		free_slots = ldu_dq_entries - model_q.size();
		exp_ack = ((attempting <= free_slots) && !m_restart) ? m_attempt : '0;
		launch = (model_q.size() != 0) && m_cq_ready && m_iq_ready && !m_restart;
		exp_cq_valid = launch;
		exp_iq_valid = launch;
		exp_cq = '0;
		exp_iq = '0;
		if (launch) begin
			head = model_q.pop_front();
			exp_cq.mdp_info = head.mdp_info;
			exp_cq.dest_pr = head.dest_pr;
			exp_cq.rob_index = head.rob_index;
			exp_iq.op = head.op;
			exp_iq.imm12 = head.imm12;
			exp_iq.a_pr = head.a_pr;
			exp_iq.a_ready = head.a_ready | wakes(head.a_pr, m_wb);
			exp_iq.a_is_zero = head.a_is_zero;
			exp_iq.cq_index = m_cq_index;
			launch_count++;
		end
		if (m_restart) begin
			model_q.delete();
			restart_count++;
		end
		else begin
			for (int i = 0; i < model_q.size(); i++) begin
				op = model_q[i];
				if (wakes(op.a_pr, m_wb))
					op.a_ready = 1'b1;
				model_q[i] = op;
			end
			for (int w = 0; w < dispatch_ways; w++) begin
				if (exp_ack[w] && m_valid[w]) begin
					op = m_ops[w];
					if (wakes(op.a_pr, m_wb))
						op.a_ready = 1'b1;
					model_q.push_back(op);
				end
			end
		end
		if (exp_ack != '0)
			ack_count++;
		m_attempt = next_dispatch_attempt_by_way;
		m_valid = next_dispatch_valid_by_way;
		m_ops = next_dispatch_op_by_way;
		m_wb = next_wb_bus_by_bank;
		m_cq_ready = next_ldu_cq_enq_ready;
		m_cq_index = next_ldu_cq_enq_index;
		m_iq_ready = next_ldu_iq_enq_ready;
		m_restart = next_rob_restart_valid;
	endtask

	// --------------------------------------------------
	// compare tasks

	task automatic check_ack(input string name, input logic [dispatch_ways-1:0] expected,
		input logic [dispatch_ways-1:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_cq(input string name, input logic exp_valid, input cq_enq_t expected,
		input logic act_valid, input cq_enq_t actual);
		check_count++;
		if ({act_valid, actual} !== {exp_valid, expected}) begin
			error_count++;
			$display("MISMATCH %s: expected valid=%b data=%h, actual valid=%b data=%h",
				name, exp_valid, expected, act_valid, actual);
		end
	endtask

	task automatic check_iq(input string name, input logic exp_valid, input iq_enq_t expected,
		input logic act_valid, input iq_enq_t actual);
		check_count++;
		if ({act_valid, actual} !== {exp_valid, expected}) begin
			error_count++;
			$display("MISMATCH %s: expected valid=%b data=%h, actual valid=%b data=%h",
				name, exp_valid, expected, act_valid, actual);
		end
	endtask

	initial begin
		#(timeout_ns);
		$display("ERROR: run did not finish within %0d ns, stopped by watchdog", timeout_ns);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		lfsr = 16'd22436;
		error_count = 0;
		assert_errors = 0;
		check_count = 0;
		launch_count = 0;
		ack_count = 0;
		restart_count = 0;
		next_dispatch_attempt_by_way = '0;
		next_dispatch_valid_by_way = '0;
		next_dispatch_op_by_way = '0;
		next_wb_bus_by_bank = '0;
		next_ldu_cq_enq_ready = 1'b0;
		next_ldu_cq_enq_index = '0;
		next_ldu_iq_enq_ready = 1'b0;
		next_rob_restart_valid = 1'b0;
		{m_attempt, m_valid, m_ops, m_wb} = '0;
		{m_cq_ready, m_cq_index, m_iq_ready, m_restart} = '0;
		{exp_ack, exp_cq_valid, exp_cq, exp_iq_valid, exp_iq} = '0;

		wait (nRST === 1'b1);
		check_ack("reset_ack", '0, last_dispatch_ack_by_way);
		check_cq("reset_cq", 1'b0, '0, last_ldu_cq_enq_valid, last_ldu_cq_enq);
		check_iq("reset_iq", 1'b0, '0, last_ldu_iq_enq_valid, last_ldu_iq_enq);

		for (int c = 0; c < num_cycles; c++) begin
			drive_inputs();
			@(posedge CLK);
			model_step();
			@(negedge CLK);
			check_ack("ack", exp_ack, last_dispatch_ack_by_way);
			check_cq("cq_enq", exp_cq_valid, exp_cq, last_ldu_cq_enq_valid, last_ldu_cq_enq);
			check_iq("iq_enq", exp_iq_valid, exp_iq, last_ldu_iq_enq_valid, last_ldu_iq_enq);
		end

		assert_errors = u_ldu_dq_wrapper.u_ldu_dq.u_ldu_dq_sva.assert_fail_count;
		$display("checks=%0d errors=%0d sva=%0d launches=%0d ack_cycles=%0d restarts=%0d",
			check_count, error_count, assert_errors, launch_count, ack_count,
			restart_count);
		if (error_count == 0 && assert_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
	output logic CLK,
	output logic nRST
);

	// 10 ns period
	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// held low for 5 rising edges, released on a falling edge
	initial begin
		nRST = 1'b0;
		repeat (5) @(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;
	end

endmodule
